// ==== src/sim_pkg.sv ====
package sim_pkg;

	//////////////////////////////
	// Particle geometry
	//////////////////////////////

	// Number of animated particles
	localparam int num_particles = 10;

	// Bounce limit on both axes
	localparam int box_size = 200;

	// Screen coordinate in pixels
	typedef logic [9:0] coord_t;

	// Signed step per update
	typedef logic signed [9:0] vel_t;

	// Selects one particle record
	typedef logic [3:0] particle_idx_t;

	// Position pair and velocity pair of one particle
	typedef struct packed {
		coord_t x;
		coord_t y;
		vel_t   vx;
		vel_t   vy;
	} particle_t;

	//////////////////////////////
	// Random start positions
	//////////////////////////////

	typedef logic [12:0] rnd_t;

	// Nonzero start state for the shift register
	localparam rnd_t lfsr_seed = 13'hF;

	// Shifts between two handed out values
	localparam int lfsr_steps = 13;

	//////////////////////////////
	// Step sequencing
	//////////////////////////////

	// Idle time after each motion update
	localparam int step_wait_cycles = 64;

	// Covers both the seed count and the idle count
	typedef logic [$clog2(step_wait_cycles)-1:0] step_cnt_t;

	typedef enum logic [2:0] {
		st_seed,
		st_erase,
		st_draw,
		st_update,
		st_wait
	} sched_state_t;

endpackage

// ==== src/bus_pkg.sv ====
package bus_pkg;

	//////////////////////////////
	// Frame buffer addressing
	//////////////////////////////

	// Pixels per row, address is row * width + column
	localparam int frame_width = 640;

	// Covers 640 x 480 pixels
	typedef logic [18:0] pix_addr_t;

	//////////////////////////////
	// Pixel colors
	//////////////////////////////

	// 3 bits red, 3 bits green, 2 bits blue
	typedef logic [7:0] color_t;

	// Clears an old particle
	localparam color_t color_black = 8'b000_000_00;

	// Full green for a drawn particle
	localparam color_t color_green = 8'b000_111_00;

	//////////////////////////////
	// Pixel write request
	//////////////////////////////

	// One pixel write from scheduler to bus master
	typedef struct packed {
		sim_pkg::coord_t col;
		sim_pkg::coord_t row;
		color_t          color;
	} pixel_req_t;

	// Wishbone side carries pix_addr_t on wb_adr and color_t on wb_dat

endpackage

// ==== src/lfsr_seeder.sv ====
module lfsr_seeder (
	input  logic          clock,
	input  logic          reset,
	input  logic          rnd_take,
	output logic          rnd_valid,
	output sim_pkg::rnd_t rnd
);

	// Shift register and its next state
	sim_pkg::rnd_t lfsr;
	sim_pkg::rnd_t lfsr_next;
	logic          feedback;

	// Shifts since the last take, holds at lfsr_steps
	logic [3:0] shift_cnt;

	// Value complete on this edge
	logic capture;

	// Taps 12, 3, 2 and 0
	assign feedback  = lfsr[12] ^ lfsr[3] ^ lfsr[2] ^ lfsr[0];
	assign lfsr_next = {lfsr[11:0], feedback};

	assign capture = !rnd_take && (shift_cnt == 4'(sim_pkg::lfsr_steps - 1));

	// Register never stops
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lfsr <= sim_pkg::lfsr_seed;
		end else begin
			lfsr <= lfsr_next;
		end
	end

	// Shift counting and valid flag
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			shift_cnt <= '0;
			rnd_valid <= 1'b0;
		end else if (rnd_take) begin
			// This edge already counts as one shift
			shift_cnt <= 4'd1;
			rnd_valid <= 1'b0;
		end else if (capture) begin
			shift_cnt <= 4'(sim_pkg::lfsr_steps);
			rnd_valid <= 1'b1;
		end else if (!rnd_valid) begin
			shift_cnt <= shift_cnt + 4'd1;
		end
	end

	// Latch the state that the 13th shift produces
	always_ff @(posedge clock) begin
		if (capture) begin
			rnd <= lfsr_next;
		end
	end

endmodule

// ==== src/particle_bank.sv ====
module particle_bank (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   load,
	input  logic                   load_y,
	input  sim_pkg::rnd_t          load_value,
	input  logic                   update,
	input  sim_pkg::particle_idx_t idx,
	output sim_pkg::particle_t     particle,
	output sim_pkg::coord_t        erase_x,
	output sim_pkg::coord_t        erase_y
);

	// Particle records and last drawn positions
	sim_pkg::particle_t parts     [sim_pkg::num_particles];
	sim_pkg::coord_t    erase_x_q [sim_pkg::num_particles];
	sim_pkg::coord_t    erase_y_q [sim_pkg::num_particles];

	// Velocities after the bounce check
	sim_pkg::vel_t next_vx [sim_pkg::num_particles];
	sim_pkg::vel_t next_vy [sim_pkg::num_particles];

	// Seed reduced into 1 .. box_size-1
	sim_pkg::coord_t seed_coord;

	//////////////////////////////
	// Bounce rule, one axis
	//////////////////////////////

	function automatic sim_pkg::vel_t bounce_vel(sim_pkg::coord_t pos, sim_pkg::vel_t vel);
		logic signed [11:0] pos_s;
		logic signed [11:0] vel_s;
		logic signed [11:0] sum;
		pos_s = $signed({2'b00, pos});
		vel_s = $signed({{2{vel[9]}}, vel});
		sum   = pos_s + vel_s;
		// Reverse past the far edge or at the near edge
		if (pos > sim_pkg::coord_t'(sim_pkg::box_size) || sum <= 12'sd0) begin
			return -vel;
		end
		return vel;
	endfunction

	assign seed_coord = sim_pkg::coord_t'(load_value % sim_pkg::rnd_t'(sim_pkg::box_size - 1))
		+ sim_pkg::coord_t'(1);

	// All particles evaluated in parallel
	always_comb begin
		for (int i = 0; i < sim_pkg::num_particles; i++) begin
			next_vx[i] = bounce_vel(parts[i].x, parts[i].vx);
			next_vy[i] = bounce_vel(parts[i].y, parts[i].vy);
		end
	end

	//////////////////////////////
	// Record storage
	//////////////////////////////

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < sim_pkg::num_particles; i++) begin
				parts[i].x   <= '0;
				parts[i].y   <= '0;
				// Start moving toward the origin
				parts[i].vx  <= sim_pkg::vel_t'(-(i + 2));
				parts[i].vy  <= sim_pkg::vel_t'(-(i + 1));
				erase_x_q[i] <= '0;
				erase_y_q[i] <= '0;
			end
		end else if (update) begin
			for (int i = 0; i < sim_pkg::num_particles; i++) begin
				// Current position becomes the next erase target
				erase_x_q[i] <= parts[i].x;
				erase_y_q[i] <= parts[i].y;
				parts[i].vx  <= next_vx[i];
				parts[i].vy  <= next_vy[i];
				// Move with the new velocity, 10 bit wrap
				parts[i].x   <= parts[i].x + sim_pkg::coord_t'(next_vx[i]);
				parts[i].y   <= parts[i].y + sim_pkg::coord_t'(next_vy[i]);
			end
		end else if (load) begin
			if (load_y) begin
				parts[idx].y <= seed_coord;
			end else begin
				parts[idx].x <= seed_coord;
			end
		end
	end

	// Read port for the scheduler
	assign particle = parts[idx];
	assign erase_x  = erase_x_q[idx];
	assign erase_y  = erase_y_q[idx];

endmodule

// ==== src/draw_scheduler.sv ====
module draw_scheduler (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   rnd_valid,
	input  sim_pkg::rnd_t          rnd,
	output logic                   rnd_take,
	output logic                   load,
	output logic                   load_y,
	output logic                   update,
	output sim_pkg::rnd_t          load_value,
	output sim_pkg::particle_idx_t idx,
	input  sim_pkg::particle_t     particle,
	input  sim_pkg::coord_t        erase_x,
	input  sim_pkg::coord_t        erase_y,
	output bus_pkg::pixel_req_t    pix_req,
	output logic                   pix_valid,
	input  logic                   pix_ready
);

	sim_pkg::sched_state_t state;

	// Holds seed index, particle index or idle cycles depending on state
	sim_pkg::step_cnt_t count;

	logic pix_fire;
	logic last_particle;

	assign pix_fire      = pix_valid && pix_ready;
	assign last_particle = count == sim_pkg::step_cnt_t'(sim_pkg::num_particles - 1);

	// Take each seed the cycle it shows up
	assign rnd_take   = (state == sim_pkg::st_seed) && rnd_valid;
	assign load       = rnd_take;
	assign load_value = rnd;
	// First ten seeds are x and the rest y
	assign load_y     = count >= sim_pkg::step_cnt_t'(sim_pkg::num_particles);
	assign update     = state == sim_pkg::st_update;
	assign pix_valid  = (state == sim_pkg::st_erase) || (state == sim_pkg::st_draw);

	always_comb begin
		if (state == sim_pkg::st_seed && load_y) begin
			idx = sim_pkg::particle_idx_t'(count - sim_pkg::step_cnt_t'(sim_pkg::num_particles));
		end else begin
			idx = sim_pkg::particle_idx_t'(count);
		end
	end

	// Black at the old spot and green at the current one
	always_comb begin
		if (state == sim_pkg::st_erase) begin
			pix_req = '{col: erase_x, row: erase_y, color: bus_pkg::color_black};
		end else begin
			pix_req = '{col: particle.x, row: particle.y, color: bus_pkg::color_green};
		end
	end

	//////////////////////////////
	// Phase FSM
	//////////////////////////////

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= sim_pkg::st_seed;
			count <= '0;
		end else begin
			case (state)
				sim_pkg::st_seed: begin
					if (rnd_take) begin
						if (count == sim_pkg::step_cnt_t'(2 * sim_pkg::num_particles - 1)) begin
							state <= sim_pkg::st_erase;
							count <= '0;
						end else begin
							count <= count + sim_pkg::step_cnt_t'(1);
						end
					end
				end
				// Index moves only on an accepted request
				sim_pkg::st_erase: begin
					if (pix_fire) begin
						count <= last_particle ? '0 : count + sim_pkg::step_cnt_t'(1);
						if (last_particle) begin
							state <= sim_pkg::st_draw;
						end
					end
				end
				sim_pkg::st_draw: begin
					if (pix_fire) begin
						count <= last_particle ? '0 : count + sim_pkg::step_cnt_t'(1);
						if (last_particle) begin
							state <= sim_pkg::st_update;
						end
					end
				end
				// Bank moves every particle in this one cycle
				sim_pkg::st_update: begin
					state <= sim_pkg::st_wait;
					count <= '0;
				end
				sim_pkg::st_wait: begin
					if (count == sim_pkg::step_cnt_t'(sim_pkg::step_wait_cycles - 1)) begin
						state <= sim_pkg::st_erase;
						count <= '0;
					end else begin
						count <= count + sim_pkg::step_cnt_t'(1);
					end
				end
				default: begin
					state <= sim_pkg::st_seed;
					count <= '0;
				end
			endcase
		end
	end

endmodule

// ==== src/wb_pixel_master.sv ====
module wb_pixel_master (
	input  logic                clock,
	input  logic                reset,
	input  bus_pkg::pixel_req_t pix_req,
	input  logic                pix_valid,
	output logic                pix_ready,
	output logic                wb_cyc,
	output logic                wb_stb,
	output logic                wb_we,
	output bus_pkg::pix_addr_t  wb_adr,
	output bus_pkg::color_t     wb_dat,
	input  logic                wb_ack
);

	// Linear address of the incoming request
	bus_pkg::pix_addr_t req_adr;

	// Holding slot in front of the bus
	logic               pend_valid;
	bus_pkg::pix_addr_t pend_adr;
	bus_pkg::color_t    pend_dat;

	logic accept;
	logic launch;

	assign req_adr = bus_pkg::pix_addr_t'(pix_req.row) * bus_pkg::pix_addr_t'(bus_pkg::frame_width)
		+ bus_pkg::pix_addr_t'(pix_req.col);

	// Slot frees up while the bus cycle still runs
	assign pix_ready = !pend_valid;
	assign accept    = pix_valid && pix_ready;
	// Start only from idle, which leaves a low cycle after each ack
	assign launch    = pend_valid && !wb_cyc;

	// Classic single write
	assign wb_stb = wb_cyc;
	assign wb_we  = wb_cyc;

	//////////////////////////////
	// Bus cycle control
	//////////////////////////////

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pend_valid <= 1'b0;
			wb_cyc     <= 1'b0;
			wb_adr     <= '0;
			wb_dat     <= '0;
		end else begin
			if (accept) begin
				pend_valid <= 1'b1;
			end else if (launch) begin
				pend_valid <= 1'b0;
			end
			if (launch) begin
				wb_cyc <= 1'b1;
				// Address and data frozen until ack
				wb_adr <= pend_adr;
				wb_dat <= pend_dat;
			end else if (wb_cyc && wb_ack) begin
				wb_cyc <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			pend_adr <= req_adr;
			pend_dat <= pix_req.color;
		end
	end

endmodule

// ==== src/particle_sim_top.sv ====
module particle_sim_top (
	input  logic               clock,
	input  logic               reset,
	output logic               wb_cyc,
	output logic               wb_stb,
	output logic               wb_we,
	output bus_pkg::pix_addr_t wb_adr,
	output bus_pkg::color_t    wb_dat,
	input  logic               wb_ack
);

	// Seeder to scheduler
	logic          rnd_valid;
	logic          rnd_take;
	sim_pkg::rnd_t rnd;

	// Scheduler and bank
	logic                   load;
	logic                   load_y;
	logic                   update;
	sim_pkg::rnd_t          load_value;
	sim_pkg::particle_idx_t idx;
	sim_pkg::particle_t     particle;
	sim_pkg::coord_t        erase_x;
	sim_pkg::coord_t        erase_y;

	// Scheduler to bus master
	bus_pkg::pixel_req_t pix_req;
	logic                pix_valid;
	logic                pix_ready;

	//////////////////////////////
	// Stage pipeline
	//////////////////////////////

	lfsr_seeder u_seeder (
		.clock     (clock),
		.reset     (reset),
		.rnd_take  (rnd_take),
		.rnd_valid (rnd_valid),
		.rnd       (rnd)
	);

	particle_bank u_bank (
		.clock      (clock),
		.reset      (reset),
		.load       (load),
		.load_y     (load_y),
		.load_value (load_value),
		.update     (update),
		.idx        (idx),
		.particle   (particle),
		.erase_x    (erase_x),
		.erase_y    (erase_y)
	);

	draw_scheduler u_sched (
		.clock      (clock),
		.reset      (reset),
		.rnd_valid  (rnd_valid),
		.rnd        (rnd),
		.rnd_take   (rnd_take),
		.load       (load),
		.load_y     (load_y),
		.update     (update),
		.load_value (load_value),
		.idx        (idx),
		.particle   (particle),
		.erase_x    (erase_x),
		.erase_y    (erase_y),
		.pix_req    (pix_req),
		.pix_valid  (pix_valid),
		.pix_ready  (pix_ready)
	);

	// Frame buffer port
	wb_pixel_master u_master (
		.clock     (clock),
		.reset     (reset),
		.pix_req   (pix_req),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat    (wb_dat),
		.wb_ack    (wb_ack)
	);

endmodule

// ==== verif/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////
// Reference model
//////////////////////////////

// One expected or observed pixel write
typedef struct packed {
	bus_pkg::pix_addr_t adr;
	bus_pkg::color_t    dat;
} wb_write_t;

// Left shift, feedback from bits 12, 3, 2 and 0
function automatic int lfsr_shift(int state);
	int fb;
	fb = ((state >> 12) ^ (state >> 3) ^ (state >> 2) ^ state) & 1;
	return ((state << 1) | fb) & 32'h1fff;
endfunction

// Random value folded into 1 .. box_size-1
function automatic int start_coord(int value);
	return (value % (sim_pkg::box_size - 1)) + 1;
endfunction

// Row major frame buffer layout
function automatic int frame_addr(int col, int row);
	return row * bus_pkg::frame_width + col;
endfunction

// 2 past the far edge, 1 at the near edge, 0 keeps going
function automatic int reversal_kind(int pos, int vel);
	if (pos > sim_pkg::box_size) begin
		return 2;
	end
	if (pos + vel <= 0) begin
		return 1;
	end
	return 0;
endfunction

// One axis of the bounce step, with edge tallies
task automatic move_axis(inout int pos, inout int vel, inout int low, inout int high);
	int kind;
	kind = reversal_kind(pos, vel);
	if (kind != 0) begin
		vel = -vel;
	end
	if (kind == 1) begin
		low++;
	end
	if (kind == 2) begin
		high++;
	end
	// Coordinates are 10 bits wide
	pos = (pos + vel) & 32'h3ff;
endtask

// Full write sequence, erase then draw per step
task automatic build_expected(input int steps, ref wb_write_t q[$],
		output int low_bounces, output int high_bounces);
	int px [sim_pkg::num_particles];
	int py [sim_pkg::num_particles];
	int vx [sim_pkg::num_particles];
	int vy [sim_pkg::num_particles];
	int ex [sim_pkg::num_particles];
	int ey [sim_pkg::num_particles];
	int state;
	wb_write_t w;
	low_bounces  = 0;
	high_bounces = 0;
	state        = int'(sim_pkg::lfsr_seed);
	// Every value is 13 shifts after the one before
	for (int k = 0; k < 2 * sim_pkg::num_particles; k++) begin
		for (int s = 0; s < sim_pkg::lfsr_steps; s++) begin
			state = lfsr_shift(state);
		end
		if (k < sim_pkg::num_particles) begin
			px[k] = start_coord(state);
		end else begin
			py[k - sim_pkg::num_particles] = start_coord(state);
		end
	end
	for (int i = 0; i < sim_pkg::num_particles; i++) begin
		vx[i] = -(i + 2);
		vy[i] = -(i + 1);
		ex[i] = 0;
		ey[i] = 0;
	end
	for (int n = 0; n < steps; n++) begin
		// Black at the previous spot
		for (int i = 0; i < sim_pkg::num_particles; i++) begin
			w.adr = bus_pkg::pix_addr_t'(frame_addr(ex[i], ey[i]));
			w.dat = bus_pkg::color_black;
			q.push_back(w);
		end
		// Green at the current spot
		for (int i = 0; i < sim_pkg::num_particles; i++) begin
			w.adr = bus_pkg::pix_addr_t'(frame_addr(px[i], py[i]));
			w.dat = bus_pkg::color_green;
			q.push_back(w);
		end
		for (int i = 0; i < sim_pkg::num_particles; i++) begin
			ex[i] = px[i];
			ey[i] = py[i];
			move_axis(px[i], vx[i], low_bounces, high_bounces);
			move_axis(py[i], vy[i], low_bounces, high_bounces);
		end
	end
endtask

`endif

// ==== verif/tb_particle_sim.sv ====
module tb_particle_sim;

	localparam int num_steps       = 40;
	localparam int writes_per_step = 2 * sim_pkg::num_particles;
	localparam int total_writes    = num_steps * writes_per_step;
	// Bus stays quiet this long after reset
	localparam int seed_cycles     = 2 * sim_pkg::num_particles * sim_pkg::lfsr_steps;
	// Six cycles per write covers the worst ack delay
	localparam int timeout_cycles  = num_steps * (writes_per_step * 6 + 70) + 400;

	logic               clock  = 1'b0;
	logic               reset  = 1'b1;
	logic               wb_ack = 1'b0;
	logic               wb_cyc;
	logic               wb_stb;
	logic               wb_we;
	bus_pkg::pix_addr_t wb_adr;
	bus_pkg::color_t    wb_dat;

	`include "tb_model.svh"

	// Expected writes and writes acked but not yet compared
	wb_write_t expected_q[$];
	wb_write_t acked_q[$];

	int write_count = 0;
	int cycle_count = 0;

	// Frame buffer slave state
	logic [31:0] rng_state = 32'h41db_bea7;
	logic        in_cycle  = 1'b0;
	int          wait_left = 0;
	wb_write_t   held;

	always #4 clock = ~clock;

	particle_sim_top u_dut (
		.clock  (clock),
		.reset  (reset),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_we  (wb_we),
		.wb_adr (wb_adr),
		.wb_dat (wb_dat),
		.wb_ack (wb_ack)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t %s: got 'h%0h, expected 'h%0h",
				$time, what, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	//////////////////////////////
	// Frame buffer slave
	//////////////////////////////

	// Ack after 0 to 3 wait cycles
	always @(negedge clock) begin
		if (cycle_count < seed_cycles) begin
			check_value("bus idle until seeding ends", 32'({wb_cyc, wb_stb}), 32'd0);
		end
		check_value("wb_stb follows wb_cyc", 32'(wb_stb), 32'(wb_cyc));
		if (wb_ack) begin
			// Cycle closed on the last rising edge
			wb_ack   <= 1'b0;
			in_cycle = 1'b0;
		end else if (wb_cyc) begin
			check_value("wb_we during write", 32'(wb_we), 32'd1);
			if (!in_cycle) begin
				in_cycle  = 1'b1;
				held.adr  = wb_adr;
				held.dat  = wb_dat;
				rng_state = xorshift32(rng_state);
				wait_left = int'(rng_state % 32'd4);
			end else begin
				check_value("wb_adr stable until ack", 32'(wb_adr), 32'(held.adr));
				check_value("wb_dat stable until ack", 32'(wb_dat), 32'(held.dat));
			end
			if (wait_left == 0) begin
				wb_ack <= 1'b1;
				acked_q.push_back(held);
			end else begin
				wait_left--;
			end
		end
	end

	//////////////////////////////
	// Compare and count
	//////////////////////////////

	always @(posedge clock) begin : compare_writes
		wb_write_t seen;
		wb_write_t want;
		if (acked_q.size() > 0) begin
			seen = acked_q.pop_front();
			if (expected_q.size() == 0) begin
				$display("Extra write to address 'h%0h after the expected sequence", seen.adr);
				$display("TEST RESULT: FAIL");
				$fatal(1, "unexpected write");
			end else begin
				want = expected_q.pop_front();
				// Step number and slot within the step
				check_value($sformatf("step %0d write %0d address",
					write_count / writes_per_step, write_count % writes_per_step),
					32'(seen.adr), 32'(want.adr));
				check_value($sformatf("step %0d write %0d color",
					write_count / writes_per_step, write_count % writes_per_step),
					32'(seen.dat), 32'(want.dat));
				write_count++;
			end
		end
	end

	// Cycle counter and run limit
	always @(posedge clock) begin
		if (!reset) begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= timeout_cycles) begin
				$display("Timeout after %0d cycles, only %0d of %0d writes seen",
					cycle_count, write_count, total_writes);
				$display("TEST RESULT: FAIL");
				$fatal(1, "run limit reached");
			end
		end
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int low_bounces;
		int high_bounces;
		build_expected(num_steps, expected_q, low_bounces, high_bounces);
		$display("Reference holds %0d writes, %0d near edge and %0d far edge reversals",
			expected_q.size(), low_bounces, high_bounces);
		// Both box edges must be hit within the run
		if (low_bounces == 0 || high_bounces == 0) begin
			$display("The expected sequence has no reversal at one of the box edges");
			$display("TEST RESULT: FAIL");
			$fatal(1, "edge reversals not covered");
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		while (write_count < total_writes) begin
			@(negedge clock);
		end
		// Nothing more may arrive during the idle phase
		repeat (20) @(negedge clock);
		if (write_count == total_writes && expected_q.size() == 0 && acked_q.size() == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("Saw %0d writes, %0d expected writes left unmatched",
				write_count, expected_q.size());
			$display("TEST RESULT: FAIL");
			$fatal(1, "write count wrong");
		end
	end

endmodule

// ==== all.f ====
+incdir+verif
src/sim_pkg.sv
src/bus_pkg.sv
src/lfsr_seeder.sv
src/particle_bank.sv
src/draw_scheduler.sv
src/wb_pixel_master.sv
src/particle_sim_top.sv
verif/tb_particle_sim.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_particle_sim
FILELIST  := all.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verif/tb_model.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
